//--- testbench/decode_stimulus.txt
# name instr imm pc pcNow wb exFwd memFwd wrReg fwd lbi link en bFlag jFlag regJmp halt
# then expected reg1Data reg2Data jmpData pcSel nextPC, all values in hex
reset  0000 0000 0100 0200 0000 0000 0000 0 0 0 0 0 0 0 0 0 0000 0000 0000 0 0102
reset  0140 0000 0100 0200 0000 0000 0000 0 0 0 0 0 0 0 0 0 0000 0000 0000 0 0102
reset  0380 0000 0100 0200 0000 0000 0000 0 0 0 0 0 0 0 0 0 0000 0000 0000 0 0102
reset  05C0 0000 0100 0200 0000 0000 0000 0 0 0 0 0 0 0 0 0 0000 0000 0000 0 0102
reset  07E0 0000 0100 0200 0000 0000 0000 0 0 0 0 0 0 0 0 0 0000 0000 0000 0 0102
write  0100 0000 0100 0200 1111 0000 0000 1 0 0 0 1 0 0 0 0 1111 0000 0000 0 0102
write  0140 0000 0100 0200 AAAA BBBB 2222 2 1 0 0 1 0 0 0 0 1111 2222 0000 0 0102
write  0260 0000 0100 0200 AAAA 3333 2222 3 2 0 0 1 0 0 0 0 2222 3333 0000 0 0102
write  0380 4444 0100 0200 AAAA BBBB CCCC 4 0 1 0 1 0 0 0 0 3333 4444 0000 0 0102
write  04A0 0000 0100 0200 5555 BBBB 2222 5 3 0 0 1 0 0 0 0 4444 5555 0000 0 0102
write  01A0 0000 0100 0200 8001 0000 0000 6 0 0 0 1 0 0 0 0 1111 5555 0000 0 0102
write  0620 0000 0100 0200 DEAD 0000 0000 1 0 0 0 0 0 0 0 0 8001 1111 0000 0 0102
branch 6000 0010 0100 0200 0000 0000 0000 0 0 0 0 0 0 0 0 0 0000 0000 0000 1 0112
branch 6100 0010 0100 0200 0000 0000 0000 0 0 0 0 0 0 0 0 0 1111 0000 0000 0 0102
branch 6600 0010 0100 0200 0000 0000 0000 0 0 0 0 0 0 0 0 0 8001 0000 0000 0 0102
branch 6800 0010 0100 0200 0000 0000 0000 0 0 0 0 0 0 0 0 0 0000 0000 0000 0 0102
branch 6900 0010 0100 0200 0000 0000 0000 0 0 0 0 0 0 0 0 0 1111 0000 0000 1 0112
branch 6E00 0010 0100 0200 0000 0000 0000 0 0 0 0 0 0 0 0 0 8001 0000 0000 1 0112
branch 7000 0010 0100 0200 0000 0000 0000 0 0 0 0 0 0 0 0 0 0000 0000 0000 0 0102
branch 7100 0010 0100 0200 0000 0000 0000 0 0 0 0 0 0 0 0 0 1111 0000 0000 0 0102
branch 7600 0010 0100 0200 0000 0000 0000 0 0 0 0 0 0 0 0 0 8001 0000 0000 1 0112
branch 7800 0010 0100 0200 0000 0000 0000 0 0 0 0 0 0 0 0 0 0000 0000 0000 1 0112
branch 7900 0010 0100 0200 0000 0000 0000 0 0 0 0 0 0 0 0 0 1111 0000 0000 1 0112
branch 7E00 0010 0100 0200 0000 0000 0000 0 0 0 0 0 0 0 0 0 8001 0000 0000 0 0102
branch 6000 0010 0100 0200 0000 0000 0000 0 0 0 0 0 0 0 0 1 0000 0000 0000 0 0100
branch 7800 0010 0100 0200 0000 0000 0000 0 0 0 0 0 0 0 0 1 0000 0000 0000 0 0100
regjmp 0100 0004 0100 0200 0000 3000 2000 0 0 0 0 0 1 1 1 0 1111 0000 0000 1 1115
regjmp 0100 0004 0100 0200 0000 3000 2000 0 1 0 0 0 1 1 1 0 1111 0000 0000 1 2004
regjmp 0100 0004 0100 0200 0000 3000 2000 0 2 0 0 0 1 1 1 0 1111 0000 0000 1 3004
regjmp 0100 0004 0100 0200 0000 3000 2000 0 3 0 0 0 1 1 1 0 1111 0000 0000 1 3004
regjmp 0100 0004 0100 0200 0000 3000 2000 0 0 0 0 0 1 1 0 0 1111 0000 0000 1 0106
jal    3140 0000 0100 0200 0000 0000 0000 0 0 0 0 0 0 0 0 0 0202 2222 0000 0 0102
jal    0140 0000 0100 0200 7777 0000 0000 1 0 0 0 1 0 0 0 0 1111 2222 0202 0 0102
jal    0140 0000 0100 0200 7777 0000 0000 1 0 0 0 1 0 0 0 0 1111 2222 0202 0 0102
jal    0140 0000 0100 0200 7777 0000 0000 1 0 0 0 1 0 0 0 0 1111 2222 0202 0 0102
jal    0160 0000 0100 0200 9999 0000 0000 3 0 0 0 1 0 0 0 0 1111 9999 0202 0 0102
jal    0760 0000 0100 0200 0000 0000 0000 0 0 0 0 0 0 0 0 0 0202 9999 0202 0 0102

//--- flist.f
rtl/decodePkg.sv
rtl/regFile.sv
rtl/linkTracker.sv
rtl/branchResolve.sv
rtl/decodeStage.sv
testbench/decodeStage_asserts.sv
testbench/decodeStage_tb.sv

//--- Bender.yml
package:
  name: decode_stage

sources:
  - rtl/decodePkg.sv
  - rtl/regFile.sv
  - rtl/linkTracker.sv
  - rtl/branchResolve.sv
  - rtl/decodeStage.sv
  - target: test
    files:
      - testbench/decodeStage_asserts.sv
      - testbench/decodeStage_tb.sv

//--- testbench/decodeStage_tb.sv
// Testbench for the decode stage that replays vectors from a stimulus file and checks outputs
`default_nettype none

module decodeStage_tb import decodePkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   // One vector holds the DUT inputs followed by the expected outputs
   typedef struct packed {
      word_t    instr;
      word_t    imm;
      word_t    pc;
      word_t    pcNow;
      word_t    writeback;
      word_t    exFwd;
      word_t    memFwd;
      regAddr_t writeRegAddr;
      fwdSel_t  forwards;
      logic     lbi;
      logic     link;
      logic     en;
      logic     bFlag;
      logic     jFlag;
      logic     regJmp;
      logic     halt;
      word_t    expReg1;
      word_t    expReg2;
      word_t    expJmp;
      logic     expSel;
      word_t    expNext;
   } vector_t;

   logic     clk;
   logic     rstN;
   instr_t   instr;
   word_t    imm, pc, pcNow, writeback, exFwd, memFwd;
   regAddr_t writeRegAddr;
   fwdSel_t  forwards;
   logic     lbi, link, en, bFlag, jFlag, regJmp, halt;
   word_t    reg1Data, reg2Data, jmpData, nextPC;
   logic     pcSel;

   vector_t vectors[$];  // All vectors in file order
   string   names[$];    // Test name of each vector
   int      errorCount;  // Mismatches over the whole run
   int      cycleCount;
   int      cycleLimit;  // Armed once the vectors are loaded

   decodeStage u_dut (.*);

   always #50 clk = ~clk;  // 100 ns period

   // Reports a mismatch between an expected and an observed value
   task automatic checkValue(input string testName, input string label,
                             input logic [15:0] expected, input logic [15:0] actual);
      if (actual !== expected) begin
         $display("[ERROR] %s %s expected %h actual %h", testName, label, expected, actual);
         errorCount++;
      end
   endtask

   // Reads the stimulus file and skips comment lines that start with a hash
   task automatic loadVectors();
      int         fd;
      int         count;
      string      line;
      string      name;
      logic [15:0] f [21];
      vector_t    v;
      fd = $fopen("testbench/decode_stimulus.txt", "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file testbench/decode_stimulus.txt");
         errorCount++;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin
               count = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                               name, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                               f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17],
                               f[18], f[19], f[20]);
               if (count != 22) begin
                  $display("Malformed stimulus line skipped: %s", line);
                  errorCount++;
               end else begin
                  v = {f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7][2:0], f[8][1:0],
                       f[9][0], f[10][0], f[11][0], f[12][0], f[13][0], f[14][0], f[15][0],
                       f[16], f[17], f[18], f[19][0], f[20]};
                  vectors.push_back(v);
                  names.push_back(name);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // Ends the run when the vectors take far longer than they should
   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
         $display("Timeout after %0d cycles, the vectors did not finish", cycleCount);
         $display("** FAIL **");
         $finish;
      end
   end

   initial begin
      int testErrors;
      int testCount;
      int failedTests;
      clk = 1'b0;
      rstN = 1'b0;
      instr = '0;
      imm = '0;
      pc = '0;
      pcNow = '0;
      writeback = '0;
      exFwd = '0;
      memFwd = '0;
      writeRegAddr = '0;
      forwards = '0;
      {lbi, link, en, bFlag, jFlag, regJmp, halt} = '0;
      errorCount = 0;
      cycleCount = 0;
      cycleLimit = 0;
      testErrors = 0;
      testCount = 0;
      failedTests = 0;
      loadVectors();
      cycleLimit = 2 * vectors.size() + 20;
      repeat (10) @(posedge clk);
      rstN <= 1'b1;
      for (int i = 0; i < vectors.size(); i++) begin
         @(posedge clk);
         instr        <= vectors[i].instr;
         imm          <= vectors[i].imm;
         pc           <= vectors[i].pc;
         pcNow        <= vectors[i].pcNow;
         writeback    <= vectors[i].writeback;
         exFwd        <= vectors[i].exFwd;
         memFwd       <= vectors[i].memFwd;
         writeRegAddr <= vectors[i].writeRegAddr;
         forwards     <= vectors[i].forwards;
         lbi          <= vectors[i].lbi;
         link         <= vectors[i].link;
         en           <= vectors[i].en;
         bFlag        <= vectors[i].bFlag;
         jFlag        <= vectors[i].jFlag;
         regJmp       <= vectors[i].regJmp;
         halt         <= vectors[i].halt;
         @(negedge clk);  // Outputs have settled half a cycle after the drive
         testErrors -= errorCount;
         checkValue(names[i], "reg1Data", vectors[i].expReg1, reg1Data);
         checkValue(names[i], "reg2Data", vectors[i].expReg2, reg2Data);
         checkValue(names[i], "jmpData", vectors[i].expJmp, jmpData);
         checkValue(names[i], "pcSel", {15'd0, vectors[i].expSel}, {15'd0, pcSel});
         checkValue(names[i], "nextPC", vectors[i].expNext, nextPC);
         testErrors += errorCount;
         if (i == vectors.size() - 1 || names[i + 1] != names[i]) begin
            testCount++;
            if (testErrors != 0) failedTests++;
            $display("Test %s finished with %0d errors", names[i], testErrors);
            testErrors = 0;
         end
      end
      @(negedge clk);  // The bound properties still sample the last vector at this edge
      $display("Tests run %0d, tests failed %0d, total errors %0d, assertion failures %0d",
               testCount, failedTests, errorCount, u_dut.uAsserts.failCount);
      if (errorCount == 0 && u_dut.uAsserts.failCount == 0 && testCount > 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule : decodeStage_tb

`default_nettype wire

//--- testbench/decodeStage_asserts.sv
// Concurrent property checks on the decode stage, bound into every decodeStage instance
`default_nettype none

module decodeStage_asserts import decodePkg::*; (
   input wire logic     clk,
   input wire logic     rstN,
   input wire logic     halt,
   input wire logic     pcSel,
   input wire word_t    jmpData,
   input wire logic     wrEn,
   input wire regAddr_t wrAddr,
   input wire opcode_t  opcode
);

   timeunit 1ns;
   timeprecision 100ps;

   logic linkInDecode;   // Jump-and-link sits in decode
   int   failCount = 0;  // Properties that have failed so far

   assign linkInDecode = (opcode == opJal) || (opcode == opJalr);

   // No register is written while reset is held
   assert property (@(posedge clk) !rstN |-> !wrEn)
      else begin
         $error("wrEn high during reset");
         failCount++;
      end

   // A halting processor never redirects fetch
   assert property (@(posedge clk) disable iff (!rstN) halt |-> !pcSel)
      else begin
         $error("pcSel high while halt is high");
         failCount++;
      end

   // The return address copy only moves after a link
   assert property (@(posedge clk) disable iff (!rstN)
                    !$past(linkInDecode) |-> $stable(jmpData))
      else begin
         $error("jmpData changed without a link in decode");
         failCount++;
      end

   assert property (@(posedge clk) disable iff (!rstN) linkInDecode |-> wrAddr == linkReg)
      else begin
         $error("Link in decode did not address the link register");
         failCount++;
      end

endmodule : decodeStage_asserts

bind decodeStage decodeStage_asserts uAsserts (.*);

`default_nettype wire

//--- rtl/decodeStage.sv
// Instruction decode stage with register file, link handling and branch resolution
`default_nettype none

module decodeStage import decodePkg::*; (
   input  logic     clk,
   input  logic     rstN,
   input  instr_t   instr,         // Instruction in decode
   input  word_t    imm,           // Immediate produced upstream
   input  word_t    pc,            // PC of the instruction in decode
   input  word_t    pcNow,         // PC currently in fetch
   input  word_t    writeback,     // Result leaving the WB stage
   input  word_t    exFwd,         // Result forwarded from EX
   input  word_t    memFwd,        // Result forwarded from MEM
   input  regAddr_t writeRegAddr,  // Destination of the writeback
   input  fwdSel_t  forwards,      // Forwarding select from hazard logic
   input  logic     lbi,
   input  logic     link,
   input  logic     en,
   input  logic     bFlag,
   input  logic     jFlag,
   input  logic     regJmp,
   input  logic     halt,
   output word_t    reg1Data,
   output word_t    reg2Data,
   output word_t    jmpData,       // Registered return address for fetch
   output logic     pcSel,         // Redirect fetch to nextPC
   output word_t    nextPC
);

   opcode_t  opcode;    // Major opcode
   regAddr_t rs;        // First source register
   regAddr_t rt;        // Second source register
   word_t    trueData;  // Selected write value before link and immediate muxing

   regAddr_t readAddr1;
   regAddr_t wrAddr;
   word_t    wrData;
   logic     wrEn;

   // Instruction fields
   assign opcode = instr[15:11];
   assign rs     = instr[10:8];
   assign rt     = instr[7:5];

   // Pick the value that is written back this cycle
   always_comb begin
      case (forwards)
         fwdWb:   trueData = writeback;
         fwdMem:  trueData = memFwd;
         fwdEx:   trueData = exFwd;
         default: trueData = writeback;  // Both bits set falls back to WB
      endcase
   end

   linkTracker uLinkTracker (
      .clk          (clk),
      .rstN         (rstN),
      .opcode       (opcode),
      .rs           (rs),
      .writeRegAddr (writeRegAddr),
      .trueData     (trueData),
      .imm          (imm),
      .pcNow        (pcNow),
      .lbi          (lbi),
      .link         (link),
      .en           (en),
      .readAddr1    (readAddr1),
      .wrAddr       (wrAddr),
      .wrData       (wrData),
      .wrEn         (wrEn),
      .jmpData      (jmpData)
   );

   regFile uRegFile (
      .clk       (clk),
      .rstN      (rstN),
      .readAddr1 (readAddr1),
      .readAddr2 (rt),
      .wrAddr    (wrAddr),
      .wrData    (wrData),
      .wrEn      (wrEn),
      .reg1Data  (reg1Data),
      .reg2Data  (reg2Data)
   );

   // Branches are resolved here against the first operand
   branchResolve uBranchResolve (
      .instr    (instr),
      .pc       (pc),
      .imm      (imm),
      .reg1Data (reg1Data),
      .exFwd    (exFwd),
      .memFwd   (memFwd),
      .forwards (forwards),
      .bFlag    (bFlag),
      .jFlag    (jFlag),
      .regJmp   (regJmp),
      .halt     (halt),
      .pcSel    (pcSel),
      .nextPC   (nextPC)
   );

endmodule : decodeStage

`default_nettype wire

//--- rtl/branchResolve.sv
// Conditional branch and jump resolution producing the PC select and next PC for fetch
`default_nettype none

module branchResolve import decodePkg::*; (
   input  instr_t  instr,     // Instruction in decode
   input  word_t   pc,        // PC of the instruction in decode
   input  word_t   imm,       // Sign-extended displacement
   input  word_t   reg1Data,  // First operand from the register file
   input  word_t   exFwd,     // Operand forwarded from EX
   input  word_t   memFwd,    // Operand forwarded from MEM
   input  fwdSel_t forwards,  // Bit 1 selects EX and bit 0 selects MEM
   input  logic    bFlag,     // External branch marker
   input  logic    jFlag,     // Unconditional jump
   input  logic    regJmp,    // Target is register based
   input  logic    halt,
   output logic    pcSel,
   output word_t   nextPC
);

   opcode_t     opcode;    // Major opcode field
   branchCond_t cond;      // Condition encoded in the low opcode bits
   logic        isBranch;  // Instruction redirects fetch when taken
   logic        zeroFlag;  // Operand is zero
   logic        signFlag;  // Operand is negative
   logic        taken;     // Condition holds for the operand
   word_t       regVal;    // Forwarded register value for register jumps
   word_t       pcInc;     // Sequential PC

   assign opcode = instr[15:11];
   assign cond   = opcode[1:0];

   assign isBranch = (opcode[4:2] == branchPrefix) || bFlag;

   // Flags of the first operand
   assign zeroFlag = (reg1Data == '0);
   assign signFlag = reg1Data[15];

   always_comb begin
      taken = 1'b0;
      case (cond)
         condEqz: taken = zeroFlag;   // Branch if zero
         condNez: taken = !zeroFlag;  // Branch if not zero
         condLtz: taken = signFlag;   // Branch if negative
         condGez: taken = !signFlag;  // Branch if zero or positive
         default: taken = 1'b0;
      endcase
   end

   // Fetch is never redirected while the processor is halting
   assign pcSel = isBranch && !halt && (taken || jFlag);

   // The youngest producer wins when both forward paths are set
   always_comb begin
      if (forwards[1]) begin
         regVal = exFwd;
      end else if (forwards[0]) begin
         regVal = memFwd;
      end else begin
         regVal = reg1Data;  // Value already in the register file
      end
   end

   assign pcInc = pc + pcStep;

   always_comb begin
      if (halt) begin
         nextPC = pc;  // Hold the PC in place
      end else if (pcSel && !regJmp) begin
         nextPC = pcInc + imm;  // PC relative target
      end else if (pcSel) begin
         nextPC = regVal + imm;  // Register plus displacement
      end else begin
         nextPC = pcInc;
      end
   end

endmodule : branchResolve

`default_nettype wire

//--- rtl/linkTracker.sv
// Jump-and-link detection, link shadow and write port steering for the register file
`default_nettype none

module linkTracker import decodePkg::*; (
   input  logic     clk,
   input  logic     rstN,
   input  opcode_t  opcode,        // Opcode of the instruction in decode
   input  regAddr_t rs,            // First source field
   input  regAddr_t writeRegAddr,  // Destination of the instruction in writeback
   input  word_t    trueData,      // Forwarded write value chosen by the top level
   input  word_t    imm,           // Immediate for load-immediate
   input  word_t    pcNow,         // PC currently in fetch
   input  logic     lbi,           // Load-immediate writes imm instead of trueData
   input  logic     link,          // Writeback carries a return address
   input  logic     en,            // Writeback wants to write a register
   output regAddr_t readAddr1,
   output regAddr_t wrAddr,
   output word_t    wrData,
   output logic     wrEn,
   output word_t    jmpData        // Last return address written, for fetch
);

   logic jlFlag;  // Jump-and-link in decode this cycle

   logic [$bits(linkState_t)-1:0] shadowQ;  // Link flags in EX, MEM and WB
   logic [$bits(linkState_t)-1:0] shadowD;

   logic  shadowEmpty;  // No link anywhere behind decode
   logic  exLink;       // A link sits in EX
   word_t pcLink;       // Return address

   assign jlFlag = (opcode == opJal) || (opcode == opJalr);

   assign exLink      = |(shadowQ & linkEx);
   assign shadowEmpty = (shadowQ == linkIdle);

   // Advance each flag one stage per cycle, the WB flag simply drops out
   always_comb begin
      shadowD = linkIdle;
      if (jlFlag) shadowD = shadowD | linkEx;
      if (exLink) shadowD = shadowD | linkMem;
      if (|(shadowQ & linkMem)) shadowD = shadowD | linkWb;
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         shadowQ <= linkIdle;
      end else begin
         shadowQ <= shadowD;
      end
   end

   assign pcLink = pcNow + pcStep;

   // The return address wins over the load-immediate and forwarded sources
   assign wrData = (link || jlFlag || exLink) ? pcLink : (lbi ? imm : trueData);
   assign wrAddr = jlFlag ? linkReg : writeRegAddr;

   // A link in decode always writes. Normal writeback is held off while any
   // link is in flight so the same link is not written a second time
   assign wrEn = jlFlag || (en && shadowEmpty);

   // A displacement link reads back register 7 while it is in decode or EX
   assign readAddr1 = ((opcode == opJal) && (jlFlag || exLink)) ? linkReg : rs;

   // Keep a copy of the last return address for fetch
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         jmpData <= '0;
      end else if (jlFlag) begin
         jmpData <= wrData;  // Visible one cycle after the link instruction
      end
   end

endmodule : linkTracker

`default_nettype wire

//--- rtl/regFile.sv
// Eight-entry register file with two asynchronous reads and a bypassed clocked write
`default_nettype none

module regFile import decodePkg::*; (
   input  logic     clk,
   input  logic     rstN,
   input  regAddr_t readAddr1,  // First operand index, may be steered to the link register
   input  regAddr_t readAddr2,  // Second operand index
   input  regAddr_t wrAddr,
   input  word_t    wrData,
   input  logic     wrEn,
   output word_t    reg1Data,
   output word_t    reg2Data
);

   word_t regs [numRegs];  // Architectural registers

   logic hit1;  // Port 1 reads the entry being written this cycle
   logic hit2;  // Same for port 2

   // Write port
   // A single entry is updated on the rising edge when the write is enabled
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < numRegs; i++) begin
            regs[i] <= '0;  // Every register reads zero out of reset
         end
      end else if (wrEn) begin
         regs[wrAddr] <= wrData;
      end
   end

   // Bypass detection
   assign hit1 = wrEn && (readAddr1 == wrAddr);
   assign hit2 = wrEn && (readAddr2 == wrAddr);

   // Read ports are purely combinational
   // A pending write is returned directly so decode never sees stale data
   always_comb begin
      if (hit1) begin
         reg1Data = wrData;  // New value before it is stored
      end else begin
         reg1Data = regs[readAddr1];
      end
   end

   always_comb begin
      if (hit2) begin
         reg2Data = wrData;  // Same bypass for the second operand
      end else begin
         reg2Data = regs[readAddr2];
      end
   end

endmodule : regFile

`default_nettype wire

//--- rtl/decodePkg.sv
// Shared types and constants for the 16-bit pipelined decode stage
`default_nettype none

package decodePkg;

   // Widths that carry a meaning across the stage
   typedef logic [15:0] word_t;        // Data word and program counter
   typedef logic [15:0] instr_t;       // Instruction held in decode
   typedef logic [2:0]  regAddr_t;     // Index into the eight-entry register file
   typedef logic [4:0]  opcode_t;      // Major opcode in bits 15 to 11
   typedef logic [1:0]  fwdSel_t;      // Source select for the value written back
   typedef logic [1:0]  branchCond_t;  // Branch condition in bits 12 to 11

   // Register file depth follows from the 3-bit register index
   localparam int numRegs = 2 ** $bits(regAddr_t);

   // Write source encodings, value 3 falls back to writeback
   localparam fwdSel_t fwdWb  = 2'd0;  // Value leaving the WB stage
   localparam fwdSel_t fwdMem = 2'd1;  // Value forwarded from MEM
   localparam fwdSel_t fwdEx  = 2'd2;  // Value forwarded from EX

   // Jump-and-link opcodes
   localparam opcode_t opJal  = 5'b00110;  // Link and jump by displacement
   localparam opcode_t opJalr = 5'b00111;  // Link and jump through a register

   // Conditional branches share the top three opcode bits
   localparam logic [2:0] branchPrefix = 3'b011;

   // Branch conditions, all tested against the first operand
   localparam branchCond_t condEqz = 2'b00;  // Operand equals zero
   localparam branchCond_t condNez = 2'b01;  // Operand is not zero
   localparam branchCond_t condLtz = 2'b10;  // Operand is negative
   localparam branchCond_t condGez = 2'b11;  // Operand is zero or positive

   // The return address always lands in the last register
   localparam regAddr_t linkReg = 3'd7;

   // Instructions are two bytes wide
   localparam word_t pcStep = 16'd2;

   // Link shadow bits, one per downstream stage
   // Several links can be in flight so the flags are kept one-hot per stage
   // and any mix of them may be set together
   typedef enum logic [2:0] {
      linkIdle = 3'b000,  // No link anywhere behind decode
      linkEx   = 3'b001,  // A link instruction sits in EX
      linkMem  = 3'b010,  // A link instruction sits in MEM
      linkWb   = 3'b100   // A link instruction sits in WB
   } linkState_t;

endpackage : decodePkg

`default_nettype wire
